// File: design/seg_pkg.sv
`default_nettype none

package seg_pkg;

    // --------------------------------------------------------------------------
    // segmented bus format
    // --------------------------------------------------------------------------

    localparam int seg_count  = 8;
    localparam int seg_bytes  = 16;
    localparam int seg_bits   = seg_bytes * 8;
    localparam int word_bytes = seg_count * seg_bytes;

    // each segment carries a 4-bit count of unused high bytes.
    localparam int mty_bits = $clog2(seg_bytes);

    typedef logic [word_bytes*8-1:0]        data_t;
    typedef logic [word_bytes-1:0]          keep_t;
    typedef logic [seg_count-1:0]           seg_flags_t;
    typedef logic [$clog2(seg_count)-1:0]   seg_index_t;
    typedef logic [seg_count*mty_bits-1:0]  mty_t;

    // --------------------------------------------------------------------------
    // output beat buffer
    // --------------------------------------------------------------------------

    localparam int fifo_depth = 16;

    typedef logic [$clog2(fifo_depth)-1:0]  fifo_addr_t;
    typedef logic [$clog2(fifo_depth):0]    fifo_count_t;

    // free entries kept back for beats that are still in the pipeline
    // when input ready drops.
    localparam int ready_headroom = 4;

endpackage

`default_nettype wire

// File: design/seg_word_if.sv
`timescale 1ns/1ps
`default_nettype none

interface seg_word_if;

    import seg_pkg::*;

    logic       valid;
    data_t      data;
    seg_flags_t ena;
    seg_flags_t sop;
    seg_flags_t eop;
    seg_flags_t err;
    mty_t       mty;

    modport src (
        output valid,
        output data,
        output ena,
        output sop,
        output eop,
        output err,
        output mty
    );

    modport dst (
        input valid,
        input data,
        input ena,
        input sop,
        input eop,
        input err,
        input mty
    );

endinterface

`default_nettype wire

// File: design/seg_realigner.sv
`timescale 1ns/1ps
`default_nettype none

module seg_realigner (
    input  wire                      s_clk,
    input  wire                      s_rst,
    input  wire                      in_valid,
    input  wire seg_pkg::data_t      in_data,
    input  wire seg_pkg::seg_flags_t in_ena,
    input  wire seg_pkg::seg_flags_t in_sop,
    input  wire seg_pkg::seg_flags_t in_eop,
    input  wire seg_pkg::seg_flags_t in_err,
    input  wire seg_pkg::mty_t       in_mty,
    seg_word_if.src                  out
);

    import seg_pkg::*;

    logic       cap_valid;
    data_t      cap_data;
    seg_flags_t cap_ena;
    seg_flags_t cap_sop;
    seg_flags_t cap_eop;
    seg_flags_t cap_err;
    mty_t       cap_mty;

    data_t      save_data;
    seg_flags_t save_ena;
    seg_flags_t save_sop;
    seg_flags_t save_eop;
    seg_flags_t save_err;
    mty_t       save_mty;

    seg_index_t offset;
    seg_index_t offset_next;
    seg_flags_t start_hits;
    logic       extra_cycle;
    logic       read_en;

    data_t      shift_data;
    seg_flags_t shift_ena;
    seg_flags_t shift_sop;
    seg_flags_t shift_eop;
    seg_flags_t shift_err;
    mty_t       shift_mty;
    logic       shift_valid;
    logic       flush;
    logic       show;

    // the offset follows the one enabled start segment of an accepted word.
    always_comb begin
        start_hits  = in_ena & in_sop;
        offset_next = offset;
        if (in_valid) begin
            for (int i = 0; i < seg_count; i++) begin
                if (start_hits == seg_flags_t'(1 << i)) begin
                    offset_next = seg_index_t'(i);
                end
            end
        end
    end

    // --------------------------------------------------------------------------
    // two-word window, shifted down by the frame offset
    // --------------------------------------------------------------------------

    always_comb begin
        if (offset == '0) begin
            shift_data = cap_data;
            shift_ena  = cap_ena;
            shift_sop  = cap_sop;
            shift_eop  = cap_eop;
            shift_err  = cap_err;
            shift_mty  = cap_mty;
        end else begin
            shift_data = {cap_data, save_data}[offset*seg_bits +: word_bytes*8];
            shift_ena  = {cap_ena, save_ena}[offset +: seg_count];
            shift_sop  = {cap_sop, save_sop}[offset +: seg_count];
            shift_eop  = {cap_eop, save_eop}[offset +: seg_count];
            shift_err  = {cap_err, save_err}[offset +: seg_count];
            shift_mty  = {cap_mty, save_mty}[offset*mty_bits +: seg_count*mty_bits];
        end
    end

    // extra_cycle is only ever set while the offset is nonzero.
    assign shift_valid = cap_valid | extra_cycle;
    assign flush       = shift_valid & (|(shift_ena & shift_eop));
    assign show        = shift_valid & (read_en | (offset == '0));

    always_ff @(posedge s_clk) begin
        if (s_rst) begin
            cap_valid   <= 1'b0;
            cap_ena     <= '0;
            cap_sop     <= '0;
            cap_eop     <= '0;
            cap_err     <= '0;
            save_ena    <= '0;
            save_sop    <= '0;
            save_eop    <= '0;
            save_err    <= '0;
            offset      <= '0;
            extra_cycle <= 1'b0;
            read_en     <= 1'b0;
        end else begin
            cap_valid <= in_valid;
            cap_ena   <= in_valid ? in_ena : '0;
            cap_sop   <= in_valid ? in_sop : '0;
            cap_eop   <= in_valid ? in_eop : '0;
            cap_err   <= in_valid ? in_err : '0;
            offset    <= offset_next;
            if (shift_valid) begin
                save_ena <= cap_ena;
                save_sop <= cap_sop;
                save_err <= cap_err;
                if (offset != '0) begin
                    read_en <= 1'b1;
                end
            end
            // once the end segment has left the window the saved end flags are stale.
            if (flush) begin
                save_eop    <= '0;
                extra_cycle <= 1'b0;
                read_en     <= 1'b0;
            end else if (shift_valid) begin
                save_eop    <= cap_eop;
                extra_cycle <= (offset != '0) && (|(cap_ena & cap_eop));
            end
        end
    end

    always_ff @(posedge s_clk) begin
        cap_data <= in_data;
        cap_mty  <= in_mty;
        if (shift_valid) begin
            save_data <= cap_data;
            save_mty  <= cap_mty;
        end
    end

    assign out.valid = show;
    assign out.data  = shift_data;
    assign out.ena   = show ? shift_ena : '0;
    assign out.sop   = shift_sop;
    assign out.eop   = shift_eop;
    assign out.err   = shift_err;
    assign out.mty   = shift_mty;

endmodule

`default_nettype wire

// File: design/beat_former.sv
`timescale 1ns/1ps
`default_nettype none

module beat_former (
    input  wire             s_clk,
    input  wire             s_rst,
    seg_word_if.dst         seg,
    output seg_pkg::data_t  beat_data,
    output seg_pkg::keep_t  beat_keep,
    output logic            beat_valid,
    output logic            beat_last,
    output logic            beat_user
);

    import seg_pkg::*;

    seg_flags_t live;
    keep_t      keep_c;

    // --------------------------------------------------------------------------
    // empty count to byte keep
    // --------------------------------------------------------------------------

    always_comb begin
        live = seg.valid ? seg.ena : '0;
        for (int i = 0; i < seg_count; i++) begin
            if (!live[i]) begin
                keep_c[i*seg_bytes +: seg_bytes] = '0;
            end else if (seg.eop[i]) begin
                // the low 16 - mty bytes of an end segment carry data.
                keep_c[i*seg_bytes +: seg_bytes] =
                    {seg_bytes{1'b1}} >> seg.mty[i*mty_bits +: mty_bits];
            end else begin
                keep_c[i*seg_bytes +: seg_bytes] = '1;
            end
        end
    end

    always_ff @(posedge s_clk) begin
        if (s_rst) begin
            beat_valid <= 1'b0;
            beat_last  <= 1'b0;
            beat_user  <= 1'b0;
        end else begin
            beat_valid <= |live;
            beat_last  <= |(live & seg.eop);
            // only an error on the end segment marks the frame bad.
            beat_user  <= |(live & seg.eop & seg.err);
        end
    end

    always_ff @(posedge s_clk) begin
        beat_data <= seg.data;
        beat_keep <= keep_c;
    end

endmodule

`default_nettype wire

// File: design/stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module stream_fifo (
    input  wire                 s_clk,
    input  wire                 s_rst,
    input  wire seg_pkg::data_t beat_data,
    input  wire seg_pkg::keep_t beat_keep,
    input  wire                 beat_valid,
    input  wire                 beat_last,
    input  wire                 beat_user,
    output seg_pkg::data_t      m_axis_tdata,
    output seg_pkg::keep_t      m_axis_tkeep,
    output logic                m_axis_tvalid,
    input  wire                 m_axis_tready,
    output logic                m_axis_tlast,
    output logic                m_axis_tuser,
    output logic                s_axis_seg_tready
);

    import seg_pkg::*;

    data_t       data_mem [fifo_depth];
    keep_t       keep_mem [fifo_depth];
    logic        last_mem [fifo_depth];
    logic        user_mem [fifo_depth];

    fifo_addr_t  wr_ptr;
    fifo_addr_t  rd_ptr;
    fifo_count_t count;
    logic        push;
    logic        pop;

    assign push = beat_valid;

    // the output register reloads when it is empty or its beat is taken.
    assign pop = (count != '0) && (!m_axis_tvalid || m_axis_tready);

    assign s_axis_seg_tready = count <= fifo_count_t'(fifo_depth - ready_headroom);

    always_ff @(posedge s_clk) begin
        if (s_rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            m_axis_tvalid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr        <= rd_ptr + 1'b1;
                m_axis_tvalid <= 1'b1;
            end else if (m_axis_tready) begin
                m_axis_tvalid <= 1'b0;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge s_clk) begin
        if (push) begin
            data_mem[wr_ptr] <= beat_data;
            keep_mem[wr_ptr] <= beat_keep;
            last_mem[wr_ptr] <= beat_last;
            user_mem[wr_ptr] <= beat_user;
        end
        if (pop) begin
            m_axis_tdata <= data_mem[rd_ptr];
            m_axis_tkeep <= keep_mem[rd_ptr];
            m_axis_tlast <= last_mem[rd_ptr];
            m_axis_tuser <= user_mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// File: design/seg_to_axis_top.sv
`timescale 1ns/1ps
`default_nettype none

module seg_to_axis_top (
    input  wire                      s_clk,
    input  wire                      s_rst,
    input  wire seg_pkg::data_t      s_axis_seg_tdata,
    input  wire                      s_axis_seg_tvalid,
    output wire                      s_axis_seg_tready,
    input  wire seg_pkg::seg_flags_t s_ena,
    input  wire seg_pkg::seg_flags_t s_sop,
    input  wire seg_pkg::seg_flags_t s_eop,
    input  wire seg_pkg::seg_flags_t s_err,
    input  wire seg_pkg::mty_t       s_mty,
    output wire seg_pkg::data_t      m_axis_tdata,
    output wire seg_pkg::keep_t      m_axis_tkeep,
    output wire                      m_axis_tvalid,
    input  wire                      m_axis_tready,
    output wire                      m_axis_tlast,
    output wire                      m_axis_tuser
);

    import seg_pkg::*;

    logic  in_valid;
    data_t beat_data;
    keep_t beat_keep;
    logic  beat_valid;
    logic  beat_last;
    logic  beat_user;

    seg_word_if aligned ();

    // a word only enters the pipeline on a completed handshake.
    assign in_valid = s_axis_seg_tvalid & s_axis_seg_tready;

    seg_realigner u_realigner (
        .s_clk    (s_clk),
        .s_rst    (s_rst),
        .in_valid (in_valid),
        .in_data  (s_axis_seg_tdata),
        .in_ena   (s_ena),
        .in_sop   (s_sop),
        .in_eop   (s_eop),
        .in_err   (s_err),
        .in_mty   (s_mty),
        .out      (aligned.src)
    );

    beat_former u_beat_former (
        .s_clk      (s_clk),
        .s_rst      (s_rst),
        .seg        (aligned.dst),
        .beat_data  (beat_data),
        .beat_keep  (beat_keep),
        .beat_valid (beat_valid),
        .beat_last  (beat_last),
        .beat_user  (beat_user)
    );

    stream_fifo u_stream_fifo (
        .s_clk             (s_clk),
        .s_rst             (s_rst),
        .beat_data         (beat_data),
        .beat_keep         (beat_keep),
        .beat_valid        (beat_valid),
        .beat_last         (beat_last),
        .beat_user         (beat_user),
        .m_axis_tdata      (m_axis_tdata),
        .m_axis_tkeep      (m_axis_tkeep),
        .m_axis_tvalid     (m_axis_tvalid),
        .m_axis_tready     (m_axis_tready),
        .m_axis_tlast      (m_axis_tlast),
        .m_axis_tuser      (m_axis_tuser),
        .s_axis_seg_tready (s_axis_seg_tready)
    );

endmodule

`default_nettype wire

// File: testbench/tb_seg_to_axis.sv
`timescale 1ns/1ps
`default_nettype none

module tb_seg_to_axis;

    import seg_pkg::*;

    typedef struct {
        data_t data;
        keep_t keep;
        logic  last;
        logic  user;
    } beat_t;

    // 12 aligned, 24 offset, 12 error and 24 back-pressure frames.
    localparam int num_frames     = 72;
    localparam int timeout_cycles = 40 * num_frames + 200;

    logic       s_clk = 1'b0;
    logic       s_rst;
    data_t      s_axis_seg_tdata;
    logic       s_axis_seg_tvalid;
    logic       s_axis_seg_tready;
    seg_flags_t s_ena;
    seg_flags_t s_sop;
    seg_flags_t s_eop;
    seg_flags_t s_err;
    mty_t       s_mty;
    data_t      m_axis_tdata;
    keep_t      m_axis_tkeep;
    logic       m_axis_tvalid;
    logic       m_axis_tready;
    logic       m_axis_tlast;
    logic       m_axis_tuser;

    beat_t      exp_q [$];
    int         words_sent     = 0;
    int         words_accepted = 0;
    int         cycles         = 0;
    logic       backpressure   = 1'b0;

    always #2 s_clk = ~s_clk;

    seg_to_axis_top u_dut (
        .s_clk             (s_clk),
        .s_rst             (s_rst),
        .s_axis_seg_tdata  (s_axis_seg_tdata),
        .s_axis_seg_tvalid (s_axis_seg_tvalid),
        .s_axis_seg_tready (s_axis_seg_tready),
        .s_ena             (s_ena),
        .s_sop             (s_sop),
        .s_eop             (s_eop),
        .s_err             (s_err),
        .s_mty             (s_mty),
        .m_axis_tdata      (m_axis_tdata),
        .m_axis_tkeep      (m_axis_tkeep),
        .m_axis_tvalid     (m_axis_tvalid),
        .m_axis_tready     (m_axis_tready),
        .m_axis_tlast      (m_axis_tlast),
        .m_axis_tuser      (m_axis_tuser)
    );

    task automatic stop_run();
        $display("Regression failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_value(input string name, input data_t expected, input data_t actual);
        $display("ERR time=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
        stop_run();
    endtask

    // bytes outside keep are don't care, so they are cleared before a compare.
    function automatic data_t keep_bytes(input data_t d, input keep_t k);
        data_t r;
        r = '0;
        for (int b = 0; b < word_bytes; b++) begin
            if (k[b]) begin
                r[b*8 +: 8] = d[b*8 +: 8];
            end
        end
        return r;
    endfunction

    task automatic check_beat();
        beat_t e;
        if (exp_q.size() == 0) begin
            $display("an output beat arrived at %0t while no beat was expected", $time);
            stop_run();
        end else begin
            e = exp_q.pop_front();
            assert (m_axis_tkeep == e.keep)
                else report_value("m_axis_tkeep", data_t'(e.keep), data_t'(m_axis_tkeep));
            assert (keep_bytes(m_axis_tdata, e.keep) == e.data)
                else report_value("m_axis_tdata", e.data, keep_bytes(m_axis_tdata, e.keep));
            assert (m_axis_tlast == e.last)
                else report_value("m_axis_tlast", data_t'(e.last), data_t'(m_axis_tlast));
            assert (m_axis_tuser == e.user)
                else report_value("m_axis_tuser", data_t'(e.user), data_t'(m_axis_tuser));
        end
    endtask

    // --------------------------------------------------------------------------
    // upstream driver and frame model
    // --------------------------------------------------------------------------

    task automatic send_word(input data_t data, input seg_flags_t ena, input seg_flags_t sop,
                             input seg_flags_t eop, input seg_flags_t err, input mty_t mty);
        s_axis_seg_tdata  = data;
        s_ena             = ena;
        s_sop             = sop;
        s_eop             = eop;
        s_err             = err;
        s_mty             = mty;
        s_axis_seg_tvalid = 1'b1;
        // tready only moves on a rising edge, so its value here holds for the next one.
        while (!s_axis_seg_tready) begin
            @(negedge s_clk);
        end
        @(negedge s_clk);
        words_sent++;
    endtask

    task automatic send_frame(input int start, input int nseg, input logic err_end,
                              input logic err_first);
        data_t      wd  [4];
        seg_flags_t ena [4];
        seg_flags_t sop [4];
        seg_flags_t eop [4];
        seg_flags_t err [4];
        mty_t       mty [4];
        logic [7:0] bytes_q [$];
        beat_t      bt;
        int         nwords;
        int         g;
        int         nb;
        nwords = (start + nseg - 1) / seg_count + 1;
        for (int w = 0; w < nwords; w++) begin
            for (int i = 0; i < 32; i++) begin
                wd[w][i*32 +: 32] = $urandom;
            end
            mty[w] = $urandom;
            ena[w] = '0;
            sop[w] = '0;
            eop[w] = '0;
            err[w] = '0;
            for (int s = 0; s < seg_count; s++) begin
                g = w * seg_count + s - start;
                if (g >= 0 && g < nseg) begin
                    ena[w][s] = 1'b1;
                    sop[w][s] = (g == 0);
                    eop[w][s] = (g == nseg - 1);
                    err[w][s] = (g == nseg - 1) ? err_end : (err_first && g == 0);
                    nb = (g == nseg - 1) ? seg_bytes - int'(mty[w][s*mty_bits +: mty_bits])
                                         : seg_bytes;
                    for (int b = 0; b < nb; b++) begin
                        bytes_q.push_back(wd[w][(s*seg_bytes + b)*8 +: 8]);
                    end
                end
            end
        end
        for (int k = 0; k * word_bytes < bytes_q.size(); k++) begin
            bt.data = '0;
            bt.keep = '0;
            for (int b = 0; b < word_bytes && k * word_bytes + b < bytes_q.size(); b++) begin
                bt.data[b*8 +: 8] = bytes_q[k*word_bytes + b];
                bt.keep[b]        = 1'b1;
            end
            bt.last = ((k + 1) * word_bytes >= bytes_q.size());
            bt.user = bt.last && err_end;
            exp_q.push_back(bt);
        end
        for (int w = 0; w < nwords; w++) begin
            send_word(wd[w], ena[w], sop[w], eop[w], err[w], mty[w]);
        end
        send_word(wd[0], '0, '0, '0, '0, mty[0]);
    endtask

    // --------------------------------------------------------------------------
    // output side
    // --------------------------------------------------------------------------

    always @(negedge s_clk) begin
        if (backpressure) begin
            m_axis_tready = 1'($urandom % 2);
        end else begin
            m_axis_tready = 1'b1;
        end
    end

    always @(posedge s_clk) begin
        if (!s_rst) begin
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("timeout after %0d cycles, %0d beats never arrived", cycles,
                         exp_q.size());
                stop_run();
            end else begin
                assert (s_axis_seg_tready || !u_dut.in_valid)
                    else report_value("u_dut.in_valid", '0, data_t'(u_dut.in_valid));
                // words taken in by the DUT, counted where the realigner captures them.
                if (u_dut.u_realigner.cap_valid) begin
                    words_accepted++;
                end
                if (m_axis_tvalid && m_axis_tready) begin
                    check_beat();
                end
            end
        end
    end

    initial begin
        void'($urandom(78069));
        s_rst             = 1'b1;
        s_axis_seg_tdata  = '0;
        s_axis_seg_tvalid = 1'b0;
        s_ena             = '0;
        s_sop             = '0;
        s_eop             = '0;
        s_err             = '0;
        s_mty             = '0;
        m_axis_tready     = 1'b1;
        repeat (5) @(negedge s_clk);
        s_rst = 1'b0;
        assert (!m_axis_tvalid)
            else report_value("m_axis_tvalid", '0, data_t'(m_axis_tvalid));
        assert (s_axis_seg_tready)
            else report_value("s_axis_seg_tready", data_t'(1), data_t'(s_axis_seg_tready));
        for (int i = 0; i < 12; i++) begin
            send_frame(0, 4 + int'($urandom % 17), 1'b0, 1'b0);
        end
        for (int i = 0; i < 24; i++) begin
            send_frame(1 + int'($urandom % 7), 4 + int'($urandom % 17), 1'b0, 1'b0);
        end
        for (int i = 0; i < 12; i++) begin
            send_frame(int'($urandom % 8), 4 + int'($urandom % 17), i % 2 == 0, i % 2 == 1);
        end
        backpressure = 1'b1;
        for (int i = 0; i < 24; i++) begin
            send_frame(int'($urandom % 8), 4 + int'($urandom % 17), 1'($urandom % 2), 1'b0);
        end
        s_axis_seg_tvalid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge s_clk);
        end
        // a few more cycles catch any beat beyond the last frame.
        repeat (20) @(negedge s_clk);
        if (words_sent == words_accepted) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("%0d words were sent but %0d were accepted", words_sent, words_accepted);
            stop_run();
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
design/seg_pkg.sv
design/seg_word_if.sv
design/seg_realigner.sv
design/beat_former.sv
design/stream_fifo.sv
design/seg_to_axis_top.sv
testbench/tb_seg_to_axis.sv

// File: run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_seg_to_axis -f verilog.f -o tb_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see $build_log"
    exit 1
fi

./obj_dir/tb_sim > "$sim_log" 2>&1
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status, see $sim_log"
    exit 1
fi

if grep -qx "Regression passed" "$sim_log"; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see $sim_log"
exit 1
